// ==== verilog/fp_noncomp_pkg.sv ====
// FP32 widths, operation encodings and shared types for the non-computational FPU
`default_nettype none

package fp_noncomp_pkg;

  // --------------------------------------------------------------------------
  // Format
  // --------------------------------------------------------------------------
  localparam int unsigned FP_WIDTH   = 32;
  localparam int unsigned EXP_BITS   = 8;
  localparam int unsigned MAN_BITS   = 23;
  localparam int unsigned CLASS_BITS = 10;

  // Canonical quiet NaN, positive sign and MSB of mantissa set
  localparam logic [FP_WIDTH-1:0] CANON_NAN = 32'h7FC0_0000;

  // One operand word
  // Field view for sign handling, raw view for unsigned compare and equality
  typedef union packed {
    struct packed {
      logic                sign;
      logic [EXP_BITS-1:0] exponent;
      logic [MAN_BITS-1:0] mantissa;
    } fld;
    logic [FP_WIDTH-1:0] raw;
  } fp_word_u;

  // --------------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    OP_SGNJ     = 2'd0,
    OP_MINMAX   = 2'd1,
    OP_CMP      = 2'd2,
    OP_CLASSIFY = 2'd3
  } fp_op_e;

  // Sub-operation select, carried in the rounding-mode field
  // RNE: SGNJ / MIN / LE
  // RTZ: SGNJN / MAX / LT
  // RDN: SGNJX / EQ
  // RUP: passthrough
  typedef enum logic [2:0] {
    MODE_RNE = 3'b000,
    MODE_RTZ = 3'b001,
    MODE_RDN = 3'b010,
    MODE_RUP = 3'b011
  } fp_mode_e;

  // RISC-V FCLASS mask, one-hot
  typedef enum logic [CLASS_BITS-1:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } class_mask_e;

  // Per-operand classification
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    // Operand was correctly NaN-boxed in the wide register
    logic is_boxed;
  } fp_info_t;

endpackage

`default_nettype wire

// ==== verilog/fp_operand_if.sv ====
// Decoded operands and their class info, from the classifier to both operation units
`timescale 1ns/1ns
`default_nettype none

interface fp_operand_if;
  import fp_noncomp_pkg::*;

  fp_word_u op_a;
  fp_word_u op_b;
  fp_info_t info_a;
  fp_info_t info_b;
  // Sub-operation select and inversion modifier
  fp_mode_e mode;
  logic     op_mod;

  // Classifier side
  modport src (output op_a, op_b, info_a, info_b, mode, op_mod);
  // Operation unit side
  modport dst (input op_a, op_b, info_a, info_b, mode, op_mod);

endinterface

`default_nettype wire

// ==== verilog/fp_cmp_result_if.sv ====
// Min/max and comparison results with their NV flags, from compare unit to result stage
`timescale 1ns/1ns
`default_nettype none

interface fp_cmp_result_if;
  import fp_noncomp_pkg::*;

  // Min/max word and its invalid flag
  fp_word_u minmax_res;
  logic     minmax_nv;
  // Boolean compare outcome and its invalid flag
  logic     cmp_bit;
  logic     cmp_nv;

  modport src (output minmax_res, minmax_nv, cmp_bit, cmp_nv);
  modport dst (input minmax_res, minmax_nv, cmp_bit, cmp_nv);

endinterface

`default_nettype wire

// ==== verilog/fp_operand_classify.sv ====
// Classifies both FP32 operands with the NaN-boxing check and drives the operand interface
`timescale 1ns/1ns
`default_nettype none

module fp_operand_classify (
  input  fp_noncomp_pkg::fp_word_u operand_a_i,
  input  fp_noncomp_pkg::fp_word_u operand_b_i,
  // Bit 0 for A, bit 1 for B
  input  logic [1:0]               is_boxed_i,
  input  fp_noncomp_pkg::fp_mode_e mode_i,
  input  logic                     op_mod_i,
  fp_operand_if.src                opnd
);
  import fp_noncomp_pkg::*;

  // --------------------------------------------------------------------------
  // Single-operand decode
  // --------------------------------------------------------------------------
  function automatic fp_info_t classify(input fp_word_u w, input logic boxed);
    fp_info_t info;
    logic     exp_zero;
    logic     exp_ones;
    logic     man_zero;
    exp_zero = (w.fld.exponent == '0);
    exp_ones = (w.fld.exponent == '1);
    man_zero = (w.fld.mantissa == '0);
    info.is_boxed      = boxed;
    info.is_normal     = boxed & ~exp_zero & ~exp_ones;
    info.is_subnormal  = boxed & exp_zero & ~man_zero;
    info.is_zero       = boxed & exp_zero & man_zero;
    info.is_inf        = boxed & exp_ones & man_zero;
    // Unboxed operand reads as a NaN, never a signalling one
    info.is_nan        = ~boxed | (exp_ones & ~man_zero);
    // sNaN has the mantissa MSB clear
    info.is_signalling = boxed & exp_ones & ~man_zero & ~w.fld.mantissa[MAN_BITS-1];
    return info;
  endfunction

  // --------------------------------------------------------------------------
  // Interface drive
  // --------------------------------------------------------------------------
  assign opnd.op_a   = operand_a_i;
  assign opnd.op_b   = operand_b_i;
  assign opnd.info_a = classify(operand_a_i, is_boxed_i[0]);
  assign opnd.info_b = classify(operand_b_i, is_boxed_i[1]);
  // Mode and modifier pass through untouched
  assign opnd.mode   = mode_i;
  assign opnd.op_mod = op_mod_i;

  // Exactly one of the five classes per operand
  // The class mask and both units depend on this
  always_comb begin
    assert ($onehot({opnd.info_a.is_normal, opnd.info_a.is_subnormal, opnd.info_a.is_zero,
                     opnd.info_a.is_inf, opnd.info_a.is_nan}))
      else $error("operand A class bits not one-hot");
    assert ($onehot({opnd.info_b.is_normal, opnd.info_b.is_subnormal, opnd.info_b.is_zero,
                     opnd.info_b.is_inf, opnd.info_b.is_nan}))
      else $error("operand B class bits not one-hot");
  end

endmodule

`default_nettype wire

// ==== verilog/fp_sign_class_unit.sv ====
// Sign injection on operand A and the FCLASS mask of operand A
`timescale 1ns/1ns
`default_nettype none

module fp_sign_class_unit (
  fp_operand_if.dst                     opnd,
  output fp_noncomp_pkg::fp_word_u      sgnj_res_o,
  output fp_noncomp_pkg::class_mask_e   class_mask_o
);
  import fp_noncomp_pkg::*;

  // Internal signs, unboxed operands count as positive
  logic sign_a;
  logic sign_b;

  assign sign_a = opnd.op_a.fld.sign & opnd.info_a.is_boxed;
  assign sign_b = opnd.op_b.fld.sign & opnd.info_b.is_boxed;

  // --------------------------------------------------------------------------
  // Sign injection
  // --------------------------------------------------------------------------
  always_comb begin
    // Start from A, unboxed A becomes the canonical NaN
    sgnj_res_o = opnd.info_a.is_boxed ? opnd.op_a : CANON_NAN;
    case (opnd.mode)
      // SGNJ
      MODE_RNE: sgnj_res_o.fld.sign = sign_b;
      // SGNJN
      MODE_RTZ: sgnj_res_o.fld.sign = ~sign_b;
      // SGNJX
      MODE_RDN: sgnj_res_o.fld.sign = sign_a ^ sign_b;
      // RUP and unused codes pass A raw, no boxing check
      default:  sgnj_res_o = opnd.op_a;
    endcase
  end

  // --------------------------------------------------------------------------
  // Classification
  // --------------------------------------------------------------------------
  always_comb begin
    if (opnd.info_a.is_normal) begin
      class_mask_o = opnd.op_a.fld.sign ? NEGNORM : POSNORM;
    end else if (opnd.info_a.is_subnormal) begin
      class_mask_o = opnd.op_a.fld.sign ? NEGSUBNORM : POSSUBNORM;
    end else if (opnd.info_a.is_zero) begin
      class_mask_o = opnd.op_a.fld.sign ? NEGZERO : POSZERO;
    end else if (opnd.info_a.is_inf) begin
      class_mask_o = opnd.op_a.fld.sign ? NEGINF : POSINF;
    end else if (opnd.info_a.is_signalling) begin
      class_mask_o = SNAN;
    end else begin
      // Quiet NaN, including unboxed A
      class_mask_o = QNAN;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fp_compare_unit.sv ====
// Operand ordering, min/max and LE/LT/EQ comparisons with their invalid flags
`timescale 1ns/1ns
`default_nettype none

module fp_compare_unit (
  fp_operand_if.dst    opnd,
  fp_cmp_result_if.src cmp
);
  import fp_noncomp_pkg::*;

  // --------------------------------------------------------------------------
  // Ordering
  // --------------------------------------------------------------------------
  logic any_nan;
  logic any_snan;
  logic ops_equal;
  logic a_smaller;
  logic le_bit;
  logic lt_bit;

  assign any_nan   = opnd.info_a.is_nan | opnd.info_b.is_nan;
  assign any_snan  = opnd.info_a.is_signalling | opnd.info_b.is_signalling;
  // +0 and -0 compare equal
  assign ops_equal = (opnd.op_a.raw == opnd.op_b.raw) |
                     (opnd.info_a.is_zero & opnd.info_b.is_zero);
  // Sign-magnitude order from the unsigned compare
  // flipped when a negative operand is involved
  assign a_smaller = (opnd.op_a.raw < opnd.op_b.raw) ^
                     (opnd.op_a.fld.sign | opnd.op_b.fld.sign);
  assign le_bit    = a_smaller | ops_equal;
  assign lt_bit    = a_smaller & ~ops_equal;

  // --------------------------------------------------------------------------
  // Min / max
  // --------------------------------------------------------------------------
  always_comb begin
    if (opnd.info_a.is_nan && opnd.info_b.is_nan) begin
      cmp.minmax_res = CANON_NAN;
    end else if (opnd.info_a.is_nan) begin
      cmp.minmax_res = opnd.op_b;
    end else if (opnd.info_b.is_nan) begin
      cmp.minmax_res = opnd.op_a;
    end else if (opnd.mode == MODE_RTZ) begin
      // MAX
      cmp.minmax_res = a_smaller ? opnd.op_b : opnd.op_a;
    end else begin
      // MIN, also for unused mode codes
      cmp.minmax_res = a_smaller ? opnd.op_a : opnd.op_b;
    end
  end

  // Quiet operation, only sNaN is invalid
  assign cmp.minmax_nv = any_snan;

  // --------------------------------------------------------------------------
  // Comparisons
  // --------------------------------------------------------------------------
  always_comb begin
    cmp.cmp_bit = 1'b0;
    cmp.cmp_nv  = 1'b0;
    if (any_snan) begin
      cmp.cmp_nv = 1'b1;
    end else begin
      case (opnd.mode)
        // LE and LT signal on any NaN
        MODE_RNE: begin
          if (any_nan) cmp.cmp_nv = 1'b1;
          else         cmp.cmp_bit = le_bit ^ opnd.op_mod;
        end
        MODE_RTZ: begin
          if (any_nan) cmp.cmp_nv = 1'b1;
          else         cmp.cmp_bit = lt_bit ^ opnd.op_mod;
        end
        // EQ is quiet, NaN is never equal
        MODE_RDN: cmp.cmp_bit = any_nan ? opnd.op_mod : (ops_equal ^ opnd.op_mod);
        default:  cmp.cmp_bit = 1'b0;
      endcase
    end
  end

  // Min/max never hands out an sNaN, even with sNaN inputs
  always_comb begin
    assert (!((cmp.minmax_res.fld.exponent == '1) && (cmp.minmax_res.fld.mantissa != '0) &&
              !cmp.minmax_res.fld.mantissa[MAN_BITS-1]))
      else $error("min/max result is a signalling NaN");
  end

endmodule

`default_nettype wire

// ==== verilog/fp_result_stage.sv ====
// Result select by operation, extension bit and the single output register with handshake
`timescale 1ns/1ns
`default_nettype none

module fp_result_stage (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  fp_noncomp_pkg::fp_op_e                  op_i,
  input  logic                                    op_mod_i,
  input  logic                                    in_valid_i,
  output logic                                    in_ready_o,
  input  fp_noncomp_pkg::fp_word_u                sgnj_res_i,
  input  fp_noncomp_pkg::class_mask_e             class_mask_i,
  fp_cmp_result_if.dst                            cmp,
  input  logic                                    out_ready_i,
  output logic                                    out_valid_o,
  output logic [fp_noncomp_pkg::FP_WIDTH-1:0]     result_o,
  output logic                                    nv_o,
  output logic                                    ext_bit_o,
  output logic [fp_noncomp_pkg::CLASS_BITS-1:0]   class_mask_o,
  output logic                                    is_class_o
);
  import fp_noncomp_pkg::*;

  logic [FP_WIDTH-1:0] result_d;
  logic                nv_d;
  logic                ext_d;
  logic                accept;

  // Output register state
  logic                  valid_q;
  logic [FP_WIDTH-1:0]   result_q;
  logic                  nv_q;
  logic                  ext_q;
  logic [CLASS_BITS-1:0] class_q;
  logic                  is_class_q;

  // --------------------------------------------------------------------------
  // Result select
  // --------------------------------------------------------------------------
  always_comb begin
    case (op_i)
      OP_SGNJ: begin
        result_d = sgnj_res_i;
        nv_d     = 1'b0;
        // op_mod asks for integer sign extension of the result
        ext_d    = op_mod_i ? sgnj_res_i.fld.sign : 1'b1;
      end
      OP_MINMAX: begin
        result_d = cmp.minmax_res;
        nv_d     = cmp.minmax_nv;
        // Float result, kept NaN-boxed
        ext_d    = 1'b1;
      end
      OP_CMP: begin
        result_d = {{(FP_WIDTH-1){1'b0}}, cmp.cmp_bit};
        nv_d     = cmp.cmp_nv;
        ext_d    = 1'b0;
      end
      default: begin
        // Classify
        result_d = {{(FP_WIDTH-CLASS_BITS){1'b0}}, class_mask_i};
        nv_d     = 1'b0;
        ext_d    = 1'b0;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // Output register
  // --------------------------------------------------------------------------
  // Take new data when empty or when the held item leaves this cycle
  assign in_ready_o = out_ready_i | ~valid_q;
  assign accept     = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_q   <= '0;
      nv_q       <= 1'b0;
      ext_q      <= 1'b0;
      class_q    <= '0;
      is_class_q <= 1'b0;
    end else if (accept) begin
      result_q   <= result_d;
      nv_q       <= nv_d;
      ext_q      <= ext_d;
      class_q    <= class_mask_i;
      is_class_q <= (op_i == OP_CLASSIFY);
    end
  end

  assign out_valid_o  = valid_q;
  assign result_o     = result_q;
  assign nv_o         = nv_q;
  assign ext_bit_o    = ext_q;
  assign class_mask_o = class_q;
  assign is_class_o   = is_class_q;

  // Stalled output holds everything until the consumer takes it
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(result_o) && $stable(nv_o) &&
      $stable(ext_bit_o) && $stable(class_mask_o) && $stable(is_class_o)))
    else $error("output changed under back-pressure");

endmodule

`default_nettype wire

// ==== verilog/fp_noncomp_top.sv ====
// Top level of the FP32 non-computational unit, plain ports around classifier, units and output stage
`timescale 1ns/1ns
`default_nettype none

module fp_noncomp_top (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  // Operands and operation
  input  logic [fp_noncomp_pkg::FP_WIDTH-1:0]   operand_a_i,
  input  logic [fp_noncomp_pkg::FP_WIDTH-1:0]   operand_b_i,
  input  logic [1:0]                            is_boxed_i,
  input  logic [1:0]                            op_i,
  input  logic [2:0]                            mode_i,
  input  logic                                  op_mod_i,
  // Input handshake
  input  logic                                  in_valid_i,
  output logic                                  in_ready_o,
  // Results
  output logic [fp_noncomp_pkg::FP_WIDTH-1:0]   result_o,
  output logic                                  nv_o,
  output logic                                  ext_bit_o,
  output logic [fp_noncomp_pkg::CLASS_BITS-1:0] class_mask_o,
  output logic                                  is_class_o,
  // Output handshake
  output logic                                  out_valid_o,
  input  logic                                  out_ready_i
);
  import fp_noncomp_pkg::*;

  // --------------------------------------------------------------------------
  // Internal connections
  // --------------------------------------------------------------------------
  fp_operand_if    opnd_if ();
  fp_cmp_result_if cmp_if ();

  fp_word_u    sgnj_res;
  class_mask_e class_mask;

  // Combinational front end
  fp_operand_classify u_classify (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .is_boxed_i  (is_boxed_i),
    .mode_i      (fp_mode_e'(mode_i)),
    .op_mod_i    (op_mod_i),
    .opnd        (opnd_if.src)
  );

  fp_sign_class_unit u_sign_class (
    .opnd         (opnd_if.dst),
    .sgnj_res_o   (sgnj_res),
    .class_mask_o (class_mask)
  );

  fp_compare_unit u_compare (
    .opnd (opnd_if.dst),
    .cmp  (cmp_if.src)
  );

  // Select and register, one cycle of latency
  fp_result_stage u_result (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .op_i         (fp_op_e'(op_i)),
    .op_mod_i     (op_mod_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .sgnj_res_i   (sgnj_res),
    .class_mask_i (class_mask),
    .cmp          (cmp_if.dst),
    .out_ready_i  (out_ready_i),
    .out_valid_o  (out_valid_o),
    .result_o     (result_o),
    .nv_o         (nv_o),
    .ext_bit_o    (ext_bit_o),
    .class_mask_o (class_mask_o),
    .is_class_o   (is_class_o)
  );

endmodule

`default_nettype wire

// ==== verif/fp_noncomp_clkgen.sv ====
// Testbench clock and reset source, 100 ns clock with reset held low for the first four cycles
`timescale 1ns/1ns
`default_nettype none

module fp_noncomp_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Release away from the active edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #10;
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/fp_noncomp_tb.sv ====
// Directed testbench and simulation top that checks the FP32 non-computational unit
`timescale 1ns/1ns
`default_nettype none

module fp_noncomp_tb;
  import fp_noncomp_pkg::*;

  localparam int          CLK_PERIOD   = 100;
  localparam int          DRIVE_DELAY  = 10;
  localparam int          NUM_TESTS    = 5;
  localparam int          TEST_CYCLES  = 50;
  localparam int          NUM_PAIRS    = 12;
  localparam int          STREAM_LEN   = 6;
  localparam logic [31:0] SEED         = 32'hd872;

  // Expected response for one item
  typedef struct packed {
    logic [31:0] result;
    logic        nv;
    logic        ext;
    logic [9:0]  cls;
    logic        is_class;
  } expect_t;

  logic        clk;
  logic        arst_n;
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic [1:0]  is_boxed;
  logic [1:0]  op;
  logic [2:0]  mode;
  logic        op_mod;
  logic        in_valid;
  logic        in_ready;
  logic [31:0] result;
  logic        nv;
  logic        ext_bit;
  logic [9:0]  class_mask;
  logic        is_class;
  logic        out_valid;
  logic        out_ready;

  int          checks;
  int          errors;
  int          tests_run;
  int          tests_bad;
  logic [31:0] pair_a [NUM_PAIRS];
  logic [31:0] pair_b [NUM_PAIRS];
  logic [1:0]  pair_boxed [NUM_PAIRS];

  fp_noncomp_clkgen u_clkgen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  fp_noncomp_top DUT (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .operand_a_i  (operand_a),
    .operand_b_i  (operand_b),
    .is_boxed_i   (is_boxed),
    .op_i         (op),
    .mode_i       (mode),
    .op_mod_i     (op_mod),
    .in_valid_i   (in_valid),
    .in_ready_o   (in_ready),
    .result_o     (result),
    .nv_o         (nv),
    .ext_bit_o    (ext_bit),
    .class_mask_o (class_mask),
    .is_class_o   (is_class),
    .out_valid_o  (out_valid),
    .out_ready_i  (out_ready)
  );

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic logic is_nan(input logic [31:0] w);
    return (w[30:23] == 8'hFF) && (w[22:0] != '0);
  endfunction

  // Total order key where -0 sorts below +0
  function automatic logic [31:0] order_key(input logic [31:0] w);
    return w[31] ? ~w : (w | 32'h8000_0000);
  endfunction

  // FCLASS bit index from bit 0 NEGINF up to bit 9 QNAN
  function automatic logic [9:0] class_of(input logic [31:0] w, input logic boxed);
    int idx;
    if (!boxed) begin
      idx = 9;
    end else if (w[30:23] == 8'hFF) begin
      idx = (w[22:0] == '0) ? (w[31] ? 0 : 7) : (w[22] ? 9 : 8);
    end else if (w[30:23] == 8'h00) begin
      idx = (w[22:0] == '0) ? (w[31] ? 3 : 4) : (w[31] ? 2 : 5);
    end else begin
      idx = w[31] ? 1 : 6;
    end
    return 10'b1 << idx;
  endfunction

  function automatic expect_t predict(input logic [31:0] a, input logic [31:0] b,
                                      input logic [1:0] boxed, input logic [1:0] opc,
                                      input logic [2:0] md, input logic mod);
    expect_t e;
    logic    nan_a;
    logic    nan_b;
    logic    snan_any;
    logic    eq;
    logic    lt;
    logic    bit_out;
    e        = '0;
    nan_a    = !boxed[0] || is_nan(a);
    nan_b    = !boxed[1] || is_nan(b);
    snan_any = (boxed[0] && is_nan(a) && !a[22]) || (boxed[1] && is_nan(b) && !b[22]);
    // Zeros of either sign are equal
    eq       = (a == b) || ((a[30:0] == '0) && (b[30:0] == '0));
    lt       = (order_key(a) < order_key(b)) && !eq;
    e.cls      = class_of(a, boxed[0]);
    e.is_class = (opc == OP_CLASSIFY);
    case (opc)
      OP_SGNJ: begin
        e.result = boxed[0] ? a : CANON_NAN;
        // Unboxed signs read as positive
        case (md)
          MODE_RNE: e.result[31] = boxed[1] & b[31];
          MODE_RTZ: e.result[31] = ~(boxed[1] & b[31]);
          MODE_RDN: e.result[31] = (boxed[0] & a[31]) ^ (boxed[1] & b[31]);
          default:  e.result = a;
        endcase
        e.ext = mod ? e.result[31] : 1'b1;
      end
      OP_MINMAX: begin
        if (nan_a && nan_b) begin
          e.result = CANON_NAN;
        end else if (nan_a) begin
          e.result = b;
        end else if (nan_b) begin
          e.result = a;
        end else if (md == MODE_RTZ) begin
          e.result = (order_key(a) < order_key(b)) ? b : a;
        end else begin
          e.result = (order_key(a) < order_key(b)) ? a : b;
        end
        e.nv  = snan_any;
        e.ext = 1'b1;
      end
      OP_CMP: begin
        bit_out = 1'b0;
        if (snan_any) begin
          e.nv = 1'b1;
        end else if (nan_a || nan_b) begin
          // EQ stays quiet on a qNaN
          e.nv    = (md != MODE_RDN);
          bit_out = (md == MODE_RDN) ? mod : 1'b0;
        end else begin
          bit_out = ((md == MODE_RNE) ? (lt | eq) : (md == MODE_RTZ) ? lt : eq) ^ mod;
        end
        e.result = {31'b0, bit_out};
      end
      default: e.result = {22'b0, e.cls};
    endcase
    return e;
  endfunction

  // --------------------------------------------------------------------------
  // Drive and check helpers
  // --------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("[FAIL] t=%0t ns %s: got %h, expected %h", $time, name, got, exp);
      end
  endtask

  task automatic check_cond(input logic cond, input string what);
    checks++;
    assert (cond)
      else begin
        errors++;
        $display("t=%0t ns: %s", $time, what);
      end
  endtask

  task automatic compare_outputs(input expect_t e);
    check_value("result_o", result, e.result);
    check_value("nv_o", {31'b0, nv}, {31'b0, e.nv});
    check_value("ext_bit_o", {31'b0, ext_bit}, {31'b0, e.ext});
    check_value("class_mask_o", {22'b0, class_mask}, {22'b0, e.cls});
    check_value("is_class_o", {31'b0, is_class}, {31'b0, e.is_class});
  endtask

  // Called 10 ns after a rising edge
  task automatic drive_item(input logic [31:0] a, input logic [31:0] b,
                            input logic [1:0] boxed, input logic [1:0] opc,
                            input logic [2:0] md, input logic mod);
    operand_a = a;
    operand_b = b;
    is_boxed  = boxed;
    op        = opc;
    mode      = md;
    op_mod    = mod;
    in_valid  = 1'b1;
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // Runs one item through the DUT and returns 10 ns after the edge that shows the result
  task automatic apply_and_check(input logic [31:0] a, input logic [31:0] b,
                                 input logic [1:0] boxed, input logic [1:0] opc,
                                 input logic [2:0] md, input logic mod);
    expect_t e;
    e = predict(a, b, boxed, opc, md, mod);
    drive_item(a, b, boxed, opc, md, mod);
    while (!in_ready) step_cycle();
    step_cycle();
    in_valid = 1'b0;
    while (!out_valid) step_cycle();
    compare_outputs(e);
  endtask

  task automatic report_test(input string name, input int errors_at_start);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %-14s ok", name);
    end else begin
      tests_bad++;
      $display("test %-14s %0d mismatches", name, errors - errors_at_start);
    end
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  // Ordered, signed zero, quiet NaN, two NaNs, sNaN and unboxed B
  task automatic load_pairs();
    pair_a     = '{32'h3F80_0000, 32'hC000_0000, 32'h4040_0000, 32'hC040_0000,
                   32'h3F80_0000, 32'h0000_0000, 32'h8000_0000, 32'h7FC0_0000,
                   32'h3F80_0000, 32'h7FC0_0000, 32'h7F80_0001, 32'h3F80_0000};
    pair_b     = '{32'hC000_0000, 32'h3F80_0000, 32'h4000_0000, 32'hC000_0000,
                   32'h3F80_0000, 32'h8000_0000, 32'h0000_0000, 32'h3F80_0000,
                   32'h7FC0_0001, 32'h7FE0_0000, 32'h3F80_0000, 32'h4000_0000};
    pair_boxed = '{2'b11, 2'b11, 2'b11, 2'b11, 2'b11, 2'b11,
                   2'b11, 2'b11, 2'b11, 2'b11, 2'b11, 2'b01};
  endtask

  task automatic test_sign_injection();
    int          start;
    logic [31:0] a;
    logic [31:0] b;
    start = errors;
    // Boxed bits walk all four combinations
    for (int bx = 0; bx < 4; bx++) begin
      a = $urandom;
      b = $urandom;
      for (int md = 0; md < 4; md++) begin
        for (int mo = 0; mo < 2; mo++) begin
          apply_and_check(a, b, 2'(bx), OP_SGNJ, 3'(md), 1'(mo));
        end
      end
    end
    report_test("sign_injection", start);
  endtask

  task automatic test_min_max();
    int start;
    start = errors;
    for (int k = 0; k < NUM_PAIRS; k++) begin
      apply_and_check(pair_a[k], pair_b[k], pair_boxed[k], OP_MINMAX, MODE_RNE, 1'b0);
      apply_and_check(pair_a[k], pair_b[k], pair_boxed[k], OP_MINMAX, MODE_RTZ, 1'b0);
    end
    report_test("min_max", start);
  endtask

  task automatic test_compare();
    int start;
    start = errors;
    // LE, LT and EQ with and without inversion
    for (int k = 0; k < NUM_PAIRS; k++) begin
      for (int md = 0; md < 3; md++) begin
        apply_and_check(pair_a[k], pair_b[k], pair_boxed[k], OP_CMP, 3'(md), 1'b0);
        apply_and_check(pair_a[k], pair_b[k], pair_boxed[k], OP_CMP, 3'(md), 1'b1);
      end
    end
    report_test("compare", start);
  endtask

  task automatic test_classify();
    int          start;
    logic [31:0] vals [10];
    start = errors;
    vals = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001, 32'h8000_0000, 32'h0000_0000,
             32'h0000_0001, 32'h3F80_0000, 32'h7F80_0000, 32'h7F80_0001, 32'h7FC0_0000};
    // Value k lands in class bit k
    for (int k = 0; k < 10; k++) begin
      apply_and_check(vals[k], 32'h0, 2'b11, OP_CLASSIFY, MODE_RNE, 1'b0);
      check_value("class_mask_o", {22'b0, class_mask}, 32'(1) << k);
    end
    // Unboxed A reads as a quiet NaN
    apply_and_check(32'h3F80_0000, 32'h0, 2'b10, OP_CLASSIFY, MODE_RNE, 1'b0);
    check_value("class_mask_o", {22'b0, class_mask}, 32'h200);
    report_test("classify", start);
  endtask

  task automatic test_handshake();
    int      start;
    expect_t held;
    expect_t next;
    expect_t pending [$];
    start = errors;
    // Empty the output register first
    in_valid  = 1'b0;
    out_ready = 1'b1;
    step_cycle();
    out_ready = 1'b0;
    drive_item(32'h4040_0000, 32'h3F80_0000, 2'b11, OP_MINMAX, MODE_RTZ, 1'b0);
    held = predict(32'h4040_0000, 32'h3F80_0000, 2'b11, OP_MINMAX, MODE_RTZ, 1'b0);
    check_cond(in_ready, "input not ready although the output register is empty");
    step_cycle();
    check_cond(out_valid, "result did not appear one cycle after acceptance");
    compare_outputs(held);
    // Offer a second item while the first is stalled
    drive_item(32'hBF80_0000, 32'h0, 2'b11, OP_CLASSIFY, MODE_RNE, 1'b0);
    next = predict(32'hBF80_0000, 32'h0, 2'b11, OP_CLASSIFY, MODE_RNE, 1'b0);
    repeat (3) begin
      step_cycle();
      check_value("in_ready_o", {31'b0, in_ready}, 32'h0);
      check_value("out_valid_o", {31'b0, out_valid}, 32'h1);
      compare_outputs(held);
    end
    // First item leaves and the second enters on the same edge
    out_ready = 1'b1;
    step_cycle();
    in_valid = 1'b0;
    check_value("out_valid_o", {31'b0, out_valid}, 32'h1);
    compare_outputs(next);
    // Back-to-back stream with one item per cycle
    for (int k = 0; k < STREAM_LEN; k++) begin
      drive_item($urandom, $urandom, 2'b11, 2'(k % 4), 3'(k % 2), 1'(k / 2));
      pending.push_back(predict(operand_a, operand_b, 2'b11, op, mode, op_mod));
      check_cond(in_ready, "input not ready during streaming");
      step_cycle();
      check_cond(out_valid, "streamed result missing");
      compare_outputs(pending.pop_front());
    end
    in_valid = 1'b0;
    report_test("handshake", start);
  endtask

  // --------------------------------------------------------------------------
  // Sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    checks    = 0;
    errors    = 0;
    tests_run = 0;
    tests_bad = 0;
    operand_a = '0;
    operand_b = '0;
    is_boxed  = 2'b11;
    op        = '0;
    mode      = '0;
    op_mod    = 1'b0;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    load_pairs();
    wait (arst_n === 1'b1);
    step_cycle();
    // Idle outputs straight after reset
    check_value("out_valid_o", {31'b0, out_valid}, 32'h0);
    compare_outputs('0);
    test_sign_injection();
    test_min_max();
    test_compare();
    test_classify();
    test_handshake();
    $display("summary: %0d of %0d tests clean, %0d checks, %0d errors",
             tests_run - tests_bad, tests_run, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the DUT stopped responding");
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== fp_noncomp.f ====
verilog/fp_noncomp_pkg.sv
verilog/fp_operand_if.sv
verilog/fp_cmp_result_if.sv
verilog/fp_operand_classify.sv
verilog/fp_sign_class_unit.sv
verilog/fp_compare_unit.sv
verilog/fp_result_stage.sv
verilog/fp_noncomp_top.sv
verif/fp_noncomp_clkgen.sv
verif/fp_noncomp_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fp_noncomp_tb
FILELIST  = fp_noncomp.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^all tests passed$$"

clean:
	rm -rf $(BUILD_DIR)
